// ==== logic/ahb_ram_pkg.sv ====
package ahb_ram_pkg;

    typedef logic [31:0] word_t;
    typedef logic [ 7:0] byte_t;
    typedef logic [ 3:0] lane_mask_t;
    typedef logic [13:0] mem_addr_t;    // deepest supported memory

    // request from the front end to the four lanes
    typedef struct packed {
        mem_addr_t  read_addr;
        mem_addr_t  write_addr;
        lane_mask_t write_mask;
        logic       any_write;
    } lane_ctrl_t;

    localparam word_t BOOT_BASE  = 32'h1fc0_0000;
    localparam int    BOOT_WORDS = 8;

    // counter loop that stores to a port at 0xbf800000
    localparam word_t boot_image [BOOT_WORDS] = '{
        32'h3c08_bf80,              // lui   t0,0xbf80
        32'h2409_0001,              // addiu t1,zero,1
        32'had09_0000,              // sw    t1,0(t0)
        32'h2529_0001,              // addiu t1,t1,1
        32'h1000_fffd,              // b     back to the store
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000
    };

endpackage

// ==== logic/byte_lane_ram.sv ====
`timescale 1ns/1ps

module byte_lane_ram
    import ahb_ram_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
)
(
    input  logic      HCLK,
    input  mem_addr_t read_addr,
    input  mem_addr_t write_addr,
    input  byte_t     write_data,
    input  logic      write_enable,
    output byte_t     read_data
);
    localparam int DEPTH = 2 ** ADDR_WIDTH;

    byte_t mem [DEPTH];

    always_ff @(posedge HCLK)
    begin
        if (write_enable)
            mem[write_addr[ADDR_WIDTH-1:0]] <= write_data;
        read_data <= mem[read_addr[ADDR_WIDTH-1:0]];    // old data on same-address write
    end

endmodule

// ==== logic/ahb_ram_slave.sv ====
`timescale 1ns/1ps

module ahb_ram_slave
    import ahb_ram_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
)
(
    input  logic       HCLK,
    input  logic       HRESETn,
    input  logic       HSEL,
    input  word_t      HADDR,
    input  logic [1:0] HTRANS,
    input  logic [2:0] HSIZE,
    input  logic       HWRITE,
    input  logic       HREADY,
    output logic       HREADYOUT,
    output lane_ctrl_t lane_ctrl
);
    typedef enum logic [1:0] {PH_IDLE, PH_WRITE, PH_STALL} phase_t;

    phase_t     state;
    phase_t     state_next;
    logic       accept;
    logic       write_now;
    mem_addr_t  addr_index;
    mem_addr_t  addr_q;
    lane_mask_t mask;
    lane_mask_t mask_q;

    assign accept     = HSEL && HREADY && HTRANS[1];    // NONSEQ or SEQ
    assign addr_index = mem_addr_t'(HADDR[ADDR_WIDTH+1:2]);
    assign write_now  = (state == PH_WRITE) && HREADY;

    always_comb
    begin
        case (HSIZE)
            3'b000:  mask = lane_mask_t'(4'b0001 << HADDR[1:0]);
            3'b001:  mask = HADDR[1] ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
    end

    always_comb
    begin
        state_next = state;
        case (state)
            PH_STALL:
                state_next = PH_IDLE;    // replayed read done
            default:
                if (HREADY)
                begin
                    if (accept && HWRITE)
                        state_next = PH_WRITE;
                    else if (accept && state == PH_WRITE)
                        state_next = PH_STALL;    // read right behind a write
                    else
                        state_next = PH_IDLE;
                end
        endcase
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            state <= PH_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge HCLK)
    begin
        if (accept)
        begin
            addr_q <= addr_index;
            mask_q <= mask;
        end
    end

    assign HREADYOUT = (state != PH_STALL);

    // held or replayed phases read the captured address
    assign lane_ctrl.read_addr  = (state == PH_STALL || !HREADY) ? addr_q : addr_index;
    assign lane_ctrl.write_addr = addr_q;
    assign lane_ctrl.write_mask = write_now ? mask_q : '0;
    assign lane_ctrl.any_write  = write_now;

    a_size_max: assert property (@(posedge HCLK) disable iff (!HRESETn)
        accept |-> HSIZE <= 3'b010);

    // no strobe unless a write was just accepted or its data phase is held
    a_strobe_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !$past(accept && HWRITE) && !$past(state == PH_WRITE && !HREADY)
            |-> lane_ctrl.write_mask == '0);

    a_aligned: assert property (@(posedge HCLK) disable iff (!HRESETn)
        accept |-> (HADDR & ((word_t'(1) << HSIZE) - 1)) == '0);

endmodule

// ==== logic/boot_read_merge.sv ====
`timescale 1ns/1ps

module boot_read_merge
    import ahb_ram_pkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  word_t       HADDR,
    input  logic        HSEL,
    input  logic [1:0]  HTRANS,
    input  logic        HREADY,
    input  logic        any_write,
    input  byte_t [3:0] lane_data,
    output word_t       HRDATA
);
    localparam int IDX_BITS = $clog2(BOOT_WORDS);

    logic  accept;
    logic  written;
    logic  data_phase;
    word_t boot_offset;
    word_t boot_word;
    word_t boot_q;

    assign accept      = HSEL && HREADY && HTRANS[1];
    assign boot_offset = HADDR - BOOT_BASE;

    always_comb
    begin
        boot_word = '0;    // outside the window
        if (boot_offset < BOOT_WORDS * 4)
            boot_word = boot_image[boot_offset[IDX_BITS+1:2]];
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            written    <= 1'b0;
            data_phase <= 1'b0;
        end
        else
        begin
            if (any_write)
                written <= 1'b1;    // sticky until reset
            if (HREADY)
                data_phase <= accept;
        end
    end

    // lines up with the registered RAM read
    always_ff @(posedge HCLK)
    begin
        if (accept)
            boot_q <= boot_word;
    end

    assign HRDATA = written ? lane_data : boot_q;

    // a data phase that ends without a lane write is a read
    a_rdata_known: assert property (@(posedge HCLK) disable iff (!HRESETn)
        data_phase && HREADY && !any_write |-> !$isunknown(HRDATA));

endmodule

// ==== logic/ahb_ram.sv ====
`timescale 1ns/1ps

module ahb_ram
    import ahb_ram_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
)
(
    input  logic       HCLK,
    input  logic       HRESETn,
    input  logic       HSEL,
    input  word_t      HADDR,
    input  logic [1:0] HTRANS,
    input  logic [2:0] HSIZE,
    input  logic       HWRITE,
    input  word_t      HWDATA,
    input  logic       HREADY,
    output word_t      HRDATA,
    output logic       HREADYOUT
);
    lane_ctrl_t  lane_ctrl;
    byte_t [3:0] lane_data;

    ahb_ram_slave #(
        .ADDR_WIDTH ( ADDR_WIDTH )
    )
    front_end
    (
        .HCLK      ( HCLK      ),
        .HRESETn   ( HRESETn   ),
        .HSEL      ( HSEL      ),
        .HADDR     ( HADDR     ),
        .HTRANS    ( HTRANS    ),
        .HSIZE     ( HSIZE     ),
        .HWRITE    ( HWRITE    ),
        .HREADY    ( HREADY    ),
        .HREADYOUT ( HREADYOUT ),
        .lane_ctrl ( lane_ctrl )
    );

    for (genvar i = 0; i < 4; i++)
    begin : lane
        byte_lane_ram #(
            .ADDR_WIDTH ( ADDR_WIDTH )
        )
        ram
        (
            .HCLK         ( HCLK                    ),
            .read_addr    ( lane_ctrl.read_addr     ),
            .write_addr   ( lane_ctrl.write_addr    ),
            .write_data   ( HWDATA[8*i +: 8]        ),    // little endian lanes
            .write_enable ( lane_ctrl.write_mask[i] ),
            .read_data    ( lane_data[i]            )
        );
    end

    boot_read_merge merge
    (
        .HCLK      ( HCLK                ),
        .HRESETn   ( HRESETn             ),
        .HADDR     ( HADDR               ),
        .HSEL      ( HSEL                ),
        .HTRANS    ( HTRANS              ),
        .HREADY    ( HREADY              ),
        .any_write ( lane_ctrl.any_write ),
        .lane_data ( lane_data           ),
        .HRDATA    ( HRDATA              )
    );

endmodule

// ==== verif/tb_ahb_ram.sv ====
`timescale 1ns/1ps

module tb_ahb_ram
    import ahb_ram_pkg::*;
;
    localparam int ADDR_WIDTH = 8;
    localparam int MEM_BYTES = 4 * (2 ** ADDR_WIDTH);
    localparam logic [1:0] TRANS_IDLE = 2'b00;
    localparam logic [1:0] TRANS_NONSEQ = 2'b10;
    localparam int NUM_TRANSFERS = 9 + 40 + 16 + 8 + 200 + 3;    // per test, in run order
    localparam int CYCLE_LIMIT = 4 * NUM_TRANSFERS + 50;

    logic       HCLK = 1'b0;
    logic       HRESETn;
    logic       HSEL;
    word_t      HADDR;
    logic [1:0] HTRANS;
    logic [2:0] HSIZE;
    logic       HWRITE;
    word_t      HWDATA;
    logic       HREADY;
    word_t      HRDATA;
    logic       HREADYOUT;
    logic       other_stall;    // another slave holding the bus

    byte_t model_mem [MEM_BYTES];
    logic  model_written = 1'b0;
    int    error_count = 0;
    int    check_count = 0;
    int    cycle_count = 0;

    assign HREADY = HREADYOUT & ~other_stall;

    ahb_ram #(
        .ADDR_WIDTH ( ADDR_WIDTH )
    )
    DUT
    (
        .HCLK      ( HCLK      ),
        .HRESETn   ( HRESETn   ),
        .HSEL      ( HSEL      ),
        .HADDR     ( HADDR     ),
        .HTRANS    ( HTRANS    ),
        .HSIZE     ( HSIZE     ),
        .HWRITE    ( HWRITE    ),
        .HWDATA    ( HWDATA    ),
        .HREADY    ( HREADY    ),
        .HRDATA    ( HRDATA    ),
        .HREADYOUT ( HREADYOUT )
    );

    initial
    begin
        forever #4 HCLK = ~HCLK;
    end

    function automatic word_t lane_bits(input word_t addr, input logic [2:0] size);
        word_t m;
        int    lo;
        int    nbytes;
        m = '0;
        lo = int'(addr[1:0]);
        nbytes = 1 << size;
        for (int k = 0; k < 4; k++)
            if (k >= lo && k < lo + nbytes)
                m[8*k +: 8] = 8'hff;
        return m;
    endfunction

    function automatic void store_in_model(input word_t addr, input logic [2:0] size,
                                           input word_t data);
        word_t m;
        word_t a;
        m = lane_bits(addr, size);
        for (int k = 0; k < 4; k++)
        begin
            a = {addr[31:2], 2'b00} + word_t'(k);
            if (m[8*k])
                model_mem[a[ADDR_WIDTH+1:0]] = data[8*k +: 8];
        end
        model_written = 1'b1;
    endfunction

    function automatic word_t expected_read(input word_t addr);
        word_t w;
        word_t a;
        word_t offset;
        w = '0;
        offset = addr - BOOT_BASE;
        if (!model_written)
        begin
            if (offset < word_t'(BOOT_WORDS * 4))
                w = boot_image[offset[4:2]];    // boot program until first write
        end
        else
            for (int k = 0; k < 4; k++)
            begin
                a = {addr[31:2], 2'b00} + word_t'(k);
                w[8*k +: 8] = model_mem[a[ADDR_WIDTH+1:0]];
            end
        return w;
    endfunction

    task automatic report_and_finish();
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    task automatic hold_while_busy();
        while (!HREADYOUT)
            @(negedge HCLK);
    endtask

    task automatic present_address(input word_t addr, input logic [2:0] size, input logic write);
        @(negedge HCLK);
        HSEL = 1'b1;
        HADDR = addr;
        HTRANS = TRANS_NONSEQ;
        HSIZE = size;
        HWRITE = write;
        while (!HREADY)
            @(negedge HCLK);
    endtask

    task automatic ahb_write(input word_t addr, input logic [2:0] size, input word_t data);
        present_address(addr, size, 1'b1);
        @(negedge HCLK);
        HSEL = 1'b0;
        HTRANS = TRANS_IDLE;
        HWDATA = data;
        hold_while_busy();    // lanes write at the next rising edge
        store_in_model(addr, size, data);
    endtask

    task automatic ahb_read(input word_t addr, input logic [2:0] size);
        word_t m;
        word_t exp;
        m = lane_bits(addr, size);
        exp = expected_read(addr);
        present_address(addr, size, 1'b0);
        @(negedge HCLK);
        HSEL = 1'b0;
        HTRANS = TRANS_IDLE;
        hold_while_busy();
        check_count++;
        assert ((HRDATA & m) === (exp & m))
        else
        begin
            error_count++;
            $display("MISMATCH HRDATA at %h: got %h expected %h", addr, HRDATA & m, exp & m);
        end
    endtask

    task automatic boot_window_reads();
        for (int k = 0; k < BOOT_WORDS; k++)
            ahb_read(BOOT_BASE + word_t'(4 * k), 3'b010);
        ahb_read(32'h0000_0040, 3'b010);    // outside the window
    endtask

    task automatic word_write_read();
        for (int k = 0; k < 16; k++)
        begin
            ahb_write(word_t'(4 * k), 3'b010, $urandom);
            ahb_read(word_t'(4 * k), 3'b010);
        end
        for (int k = 0; k < BOOT_WORDS; k++)
            ahb_read(BOOT_BASE + word_t'(4 * k), 3'b010);    // now aliases RAM
    endtask

    task automatic partial_lane_writes();
        word_t      addr;
        logic [2:0] size;
        for (int n = 0; n < 8; n++)
        begin
            size = (n % 2 == 1) ? 3'b001 : 3'b000;
            addr = word_t'(4 * $urandom_range(0, 15));
            if (size == 3'b000)
                addr = addr + word_t'($urandom_range(0, 3));
            else
                addr = addr + word_t'(2 * $urandom_range(0, 1));
            ahb_write(addr, size, $urandom);
            ahb_read({addr[31:2], 2'b00}, 3'b010);
        end
    endtask

    task automatic read_after_write(input word_t addr, input word_t data);
        int    low_cycles;
        word_t exp;
        present_address(addr, 3'b010, 1'b1);
        @(negedge HCLK);
        HWDATA = data;
        HWRITE = 1'b0;    // read address phase during the write data phase
        store_in_model(addr, 3'b010, data);
        exp = expected_read(addr);
        @(negedge HCLK);
        HSEL = 1'b0;
        HTRANS = TRANS_IDLE;
        low_cycles = 0;
        while (!HREADYOUT)
        begin
            low_cycles++;
            @(negedge HCLK);
        end
        check_count += 2;
        assert (low_cycles == 1)
        else
        begin
            error_count++;
            $display("MISMATCH HREADYOUT low cycles: got %h expected %h", low_cycles, 1);
        end
        assert (HRDATA === exp)
        else
        begin
            error_count++;
            $display("MISMATCH HRDATA at %h: got %h expected %h", addr, HRDATA, exp);
        end
    endtask

    task automatic random_traffic();
        word_t      addr;
        logic [2:0] size;
        for (int n = 0; n < 200; n++)
        begin
            size = 3'($urandom_range(0, 2));
            addr = word_t'(4 * $urandom_range(0, 15));
            if (size == 3'b000)
                addr = addr + word_t'($urandom_range(0, 3));
            else if (size == 3'b001)
                addr = addr + word_t'(2 * $urandom_range(0, 1));
            if ($urandom_range(0, 1) == 1)
                ahb_write(addr, size, $urandom);
            else
                ahb_read(addr, size);
        end
    endtask

    task automatic foreign_stall(input word_t addr);
        @(negedge HCLK);
        other_stall = 1'b1;
        HSEL = 1'b1;
        HADDR = addr;
        HTRANS = TRANS_NONSEQ;
        HSIZE = 3'b010;
        HWRITE = 1'b1;
        HWDATA = ~expected_read(addr);
        for (int k = 0; k < 3; k++)
        begin
            @(negedge HCLK);
            check_count++;
            assert (HREADYOUT === 1'b1)
            else
            begin
                error_count++;
                $display("MISMATCH HREADYOUT during stall: got %h expected %h", HREADYOUT, 1'b1);
            end
        end
        HSEL = 1'b0;
        HTRANS = TRANS_IDLE;
        other_stall = 1'b0;
        ahb_read(addr, 3'b010);    // must still hold the old word
    endtask

    initial
    begin
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge HCLK);
            cycle_count++;
        end
        error_count++;
        $display("timeout after %0d cycles, the DUT never finished the tests", cycle_count);
        report_and_finish();
    end

    initial
    begin
        void'($urandom(32'hdb6a_a771));
        HRESETn = 1'b0;
        HSEL = 1'b0;
        HADDR = '0;
        HTRANS = TRANS_IDLE;
        HSIZE = 3'b010;
        HWRITE = 1'b0;
        HWDATA = '0;
        other_stall = 1'b0;
        repeat (2) @(negedge HCLK);
        HRESETn = 1'b1;

        boot_window_reads();
        word_write_read();
        partial_lane_writes();
        read_after_write(32'h0000_0008, $urandom);
        read_after_write(32'h0000_0014, $urandom);
        read_after_write(32'h0000_0024, $urandom);
        read_after_write(32'h0000_0030, $urandom);
        random_traffic();
        foreign_stall(32'h0000_000c);
        @(negedge HCLK);
        report_and_finish();
    end

endmodule

// ==== vlog.f ====
logic/ahb_ram_pkg.sv
logic/byte_lane_ram.sv
logic/ahb_ram_slave.sv
logic/boot_read_merge.sv
logic/ahb_ram.sv
verif/tb_ahb_ram.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the AHB RAM testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_ahb_ram -f vlog.f \
    -o sim_ahb_ram > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_ahb_ram > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1
